/* include/wavegen_consts.svh */
`ifndef WAVEGEN_CONSTS_SVH
`define WAVEGEN_CONSTS_SVH

// sample width per channel
// must equal the parallel input width of the external serializer
`define WG_DATA_WIDTH 8

// address bits of each waveform RAM
// 10 bits gives 1024 samples per channel
`define WG_ADDRESS_WIDTH 10

// number of output channels, each with its own RAM
`define WG_CHANNELS 2

// width of the host channel select
// never below one bit, even for a single channel build
`define WG_CHANNEL_WIDTH (((`WG_CHANNELS) > 1) ? $clog2(`WG_CHANNELS) : 1)

`endif

/* source/wavegen_pkg.sv */
package wavegen_pkg;

	`include "wavegen_consts.svh"

	// one sample word as handed to the serializer
	typedef logic [`WG_DATA_WIDTH-1:0] sample_t;

	// index into one waveform RAM
	typedef logic [`WG_ADDRESS_WIDTH-1:0] address_t;

	// period length in samples
	// one extra bit so a completely filled RAM fits
	typedef logic [`WG_ADDRESS_WIDTH:0] length_t;

	// playback sequencer states
	typedef enum logic {
		seq_idle    = 1'b0,
		seq_playing = 1'b1
	} seq_state_e;

	// playback opcode from the host
	// loop repeats until stop, single plays one period
	typedef enum logic {
		mode_loop   = 1'b0,
		mode_single = 1'b1
	} play_mode_e;

endpackage

/* source/wave_write_if.sv */
`timescale 1ns/1ps

`include "wavegen_consts.svh"

// host write bundle shared by every channel RAM
// plain strobe, one sample per clock, no handshake
interface wave_write_if;

	// which channel RAM takes the sample
	logic [`WG_CHANNEL_WIDTH-1:0] channel;
	// sample position inside that RAM
	wavegen_pkg::address_t address;
	// sample value
	wavegen_pkg::sample_t data;
	// write strobe, sampled on every rising edge
	logic write_enable;

	// host side drives all four signals
	modport host (
		output channel,
		output address,
		output data,
		output write_enable
	);

	// each RAM only listens
	modport memory (
		input channel,
		input address,
		input data,
		input write_enable
	);

endinterface

/* source/waveform_ram.sv */
`timescale 1ns/1ps

`include "wavegen_consts.svh"

// sample memory of a single channel
// write port from the host bundle, read port from the sequencer
// read is registered, so data shows up one cycle after the address
module waveform_ram #(
	parameter int CHANNEL_INDEX = 0
) (
	input logic clock,
	wave_write_if.memory wr,
	input wavegen_pkg::address_t read_address,
	output wavegen_pkg::sample_t read_data
);

	localparam int unsigned CHANNEL_WIDTH = `WG_CHANNEL_WIDTH;
	localparam int unsigned DEPTH = 2 ** `WG_ADDRESS_WIDTH;

	// channel number this instance answers to, sized like the select
	localparam logic [CHANNEL_WIDTH-1:0] MY_CHANNEL = CHANNEL_INDEX[CHANNEL_WIDTH-1:0];

	// sample storage, contents undefined until the host loads them
	wavegen_pkg::sample_t memory [DEPTH];

	logic write_hit;

	// only the addressed channel stores the sample
	assign write_hit = wr.write_enable && (wr.channel == MY_CHANNEL);

	// read port is always enabled
	// both ports sit in one block, so a read of the address being
	// written in the same cycle returns the previous contents
	always_ff @(posedge clock) begin
		if (write_hit) begin
			memory[wr.address] <= wr.data;
		end
		read_data <= memory[read_address];
	end

endmodule

/* source/playback_sequencer.sv */
`timescale 1ns/1ps

// shared playback control for all channels
// steps the read address through the first length entries
// loop mode wraps at the end, single mode goes back to idle
module playback_sequencer (
	input logic clock,
	input logic reset,
	input logic start,
	input logic stop,
	input wavegen_pkg::play_mode_e mode,
	input wavegen_pkg::length_t length,
	output wavegen_pkg::address_t read_address,
	output logic playing
);

	// current and next state
	wavegen_pkg::seq_state_e state;
	wavegen_pkg::seq_state_e state_next;

	// mode and length captured at start
	wavegen_pkg::play_mode_e mode_latched;
	wavegen_pkg::play_mode_e mode_next;
	wavegen_pkg::length_t length_latched;
	wavegen_pkg::length_t length_next;

	// address counter next value
	wavegen_pkg::address_t address_next;

	// final address of the period
	wavegen_pkg::address_t last_address;
	logic at_last;

	// latched length is never 0, so this cannot underflow
	// top bit drops out, a full RAM ends at the all-ones address
	assign last_address = wavegen_pkg::address_t'(length_latched - 1'b1);
	assign at_last = (read_address == last_address);

	// playing comes straight off the state register
	assign playing = (state == wavegen_pkg::seq_playing);

	always_comb begin
		// hold everything by default
		state_next = state;
		address_next = read_address;
		mode_next = mode_latched;
		length_next = length_latched;

		if (stop) begin
			// stop has priority over start
			state_next = wavegen_pkg::seq_idle;
			address_next = '0;
		end else if (start) begin
			// start from idle or restart while playing
			state_next = wavegen_pkg::seq_playing;
			address_next = '0;
			mode_next = mode;
			// zero length plays a single sample
			if (length == '0) begin
				length_next = wavegen_pkg::length_t'(1);
			end else begin
				length_next = length;
			end
		end else if (state == wavegen_pkg::seq_playing) begin
			if (!at_last) begin
				address_next = read_address + 1'b1;
			end else begin
				// end of period, wrap to the first sample
				address_next = '0;
				// single mode is done after one period
				if (mode_latched == wavegen_pkg::mode_single) begin
					state_next = wavegen_pkg::seq_idle;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= wavegen_pkg::seq_idle;
			read_address <= '0;
			mode_latched <= wavegen_pkg::mode_loop;
			// length of one keeps address 0 inside the range while idle
			length_latched <= wavegen_pkg::length_t'(1);
		end else begin
			state <= state_next;
			read_address <= address_next;
			mode_latched <= mode_next;
			length_latched <= length_next;
		end
	end

endmodule

/* source/function_generator.sv */
`timescale 1ns/1ps

`include "wavegen_consts.svh"

// multi-channel arbitrary waveform generator
// one RAM per channel, one shared sequencer
// data_out holds one sample per channel, channel 0 in the low bits
// latency from start to first valid sample is two cycles
module function_generator (
	input logic clock,
	input logic reset,
	input logic [`WG_CHANNEL_WIDTH-1:0] channel,
	input wavegen_pkg::address_t write_address,
	input wavegen_pkg::sample_t data_in,
	input logic write_enable,
	input logic start,
	input logic stop,
	input wavegen_pkg::play_mode_e mode,
	input wavegen_pkg::length_t length,
	input logic [`WG_CHANNELS-1:0] channel_enable,
	output logic [`WG_CHANNELS*`WG_DATA_WIDTH-1:0] data_out,
	output logic sample_valid
);

	localparam int unsigned WIDTH = `WG_DATA_WIDTH;
	localparam int unsigned CHANNELS = `WG_CHANNELS;

	// write bundle fanned out to every RAM
	wave_write_if wr_bus ();

	// sequencer outputs
	wavegen_pkg::address_t read_address;
	logic playing;

	// playing delayed to line up with the RAM output
	logic playing_delayed;
	// stop seen while playing, kills the sample already in flight
	logic stop_flush;
	// RAM output is a real sample this cycle
	logic data_ready;

	// raw read data per channel
	wavegen_pkg::sample_t ram_data [CHANNELS];
	// read data with disabled channels forced to zero
	logic [CHANNELS*WIDTH-1:0] gated_word;

	// host ports go onto the bundle as they are
	assign wr_bus.channel = channel;
	assign wr_bus.address = write_address;
	assign wr_bus.data = data_in;
	assign wr_bus.write_enable = write_enable;

	playback_sequencer sequencer (
		.clock(clock),
		.reset(reset),
		.start(start),
		.stop(stop),
		.mode(mode),
		.length(length),
		.read_address(read_address),
		.playing(playing)
	);

	for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_channel
		// all RAMs read the same address every cycle
		waveform_ram #(
			.CHANNEL_INDEX(ch)
		) ram (
			.clock(clock),
			.wr(wr_bus.memory),
			.read_address(read_address),
			.read_data(ram_data[ch])
		);

		// enable is taken at the same edge as the RAM data
		assign gated_word[ch*WIDTH +: WIDTH] = channel_enable[ch] ? ram_data[ch] : '0;
	end

	// a stop drops valid one edge after it is sampled
	// single mode end lets the last sample through normally
	assign data_ready = playing_delayed && !stop_flush;

	always_ff @(posedge clock) begin
		if (reset) begin
			playing_delayed <= 1'b0;
			stop_flush <= 1'b0;
			sample_valid <= 1'b0;
			data_out <= '0;
		end else begin
			playing_delayed <= playing;
			stop_flush <= stop && playing;
			sample_valid <= data_ready;
			// output is zero whenever no sample is valid
			if (data_ready) begin
				data_out <= gated_word;
			end else begin
				data_out <= '0;
			end
		end
	end

endmodule

/* verification/function_generator_asserts.sv */
`timescale 1ns/1ps

// bound into function_generator
// sees its ports plus the sequencer address and playing flag
module function_generator_asserts (
	input logic clock,
	input logic reset,
	input logic start,
	input logic stop,
	input wavegen_pkg::length_t length,
	input wavegen_pkg::address_t read_address,
	input logic playing,
	input logic sample_valid
);

	// length the sequencer should be holding
	wavegen_pkg::length_t length_seen;
	// set by the first accepted start
	logic started;
	// number of failed assertions so far
	int failures = 0;

	always_ff @(posedge clock) begin
		if (reset) begin
			length_seen <= wavegen_pkg::length_t'(1);
			started <= 1'b0;
		end else if (start && !stop) begin
			// zero length counts as one
			length_seen <= (length == '0) ? wavegen_pkg::length_t'(1) : length;
			started <= 1'b1;
		end
	end

	valid_low_in_reset: assert property (@(posedge clock) reset |=> !sample_valid)
		else begin
			$error("sample_valid high right after a reset cycle");
			failures++;
		end

	valid_low_before_start: assert property (@(posedge clock)
		(!reset && !started) |-> !sample_valid)
		else begin
			$error("sample_valid high before any start");
			failures++;
		end

	address_in_range: assert property (@(posedge clock) disable iff (reset)
		read_address < length_seen)
		else begin
			$error("read_address outside the latched length");
			failures++;
		end

	// first sample from idle is registered at the second edge after start
	// so the third sampling edge is the first to see the flag high
	valid_after_start: assert property (@(posedge clock) disable iff (reset)
		(start && !stop && !playing) |=> !sample_valid ##1 !sample_valid ##1 sample_valid)
		else begin
			$error("sample_valid not aligned to start from idle");
			failures++;
		end

endmodule

/* verification/function_generator_checker.sv */
`timescale 1ns/1ps

`include "wavegen_consts.svh"

// watches the generator ports and predicts every output word
module function_generator_checker (
	input logic clock,
	input logic reset,
	input logic [`WG_CHANNEL_WIDTH-1:0] channel,
	input wavegen_pkg::address_t write_address,
	input wavegen_pkg::sample_t data_in,
	input logic write_enable,
	input logic start,
	input logic stop,
	input wavegen_pkg::play_mode_e mode,
	input wavegen_pkg::length_t length,
	input logic [`WG_CHANNELS-1:0] channel_enable,
	input logic [`WG_CHANNELS*`WG_DATA_WIDTH-1:0] data_out,
	input logic sample_valid
);

	localparam int W = `WG_DATA_WIDTH;
	localparam int WORD = `WG_CHANNELS * `WG_DATA_WIDTH;

	// mirror of all channel RAMs, unknown until written
	wavegen_pkg::sample_t mem [`WG_CHANNELS][2 ** `WG_ADDRESS_WIDTH];
	// playback model
	logic play;
	int addr;
	int len;
	bit single;
	// word read from the RAMs, one edge ahead of the output
	logic read_valid;
	logic [WORD-1:0] read_word;
	// predicted output
	logic exp_valid;
	logic [WORD-1:0] exp_data;
	bit seen_reset;
	string test_name;
	int test_errors;
	int errors;
	int passed;
	int failed;

	always @(posedge clock) begin
		if (reset) begin
			play = 1'b0;
			addr = 0;
			read_valid = 1'b0;
			exp_valid = 1'b0;
			exp_data = '0;
			seen_reset = 1'b1;
		end else begin
			// output takes the previous read, enable applied now
			exp_valid = read_valid;
			for (int c = 0; c < `WG_CHANNELS; c++) begin
				exp_data[c*W +: W] = (read_valid && channel_enable[c]) ? read_word[c*W +: W] : '0;
				// old contents win over a write to the same address
				read_word[c*W +: W] = mem[c][addr];
			end
			// stop throws away the sample being read
			read_valid = play && !stop;
			if (write_enable) begin
				mem[channel][write_address] = data_in;
			end
			// stop beats start, start also restarts
			if (stop) begin
				play = 1'b0;
			end else if (start) begin
				play = 1'b1;
				addr = 0;
				len = (length == '0) ? 1 : int'(length);
				single = (mode == wavegen_pkg::mode_single);
			end else if (play) begin
				if (addr == len - 1) begin
					addr = 0;
					play = !single;
				end else begin
					addr++;
				end
			end
		end
	end

	task automatic check(input string name, input logic [WORD-1:0] expected,
			input logic [WORD-1:0] actual);
		if (actual !== expected) begin
			$display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
			test_errors++;
			errors++;
		end
	endtask

	// outputs settle after the rising edge, compare mid cycle
	always @(negedge clock) begin
		if (seen_reset) begin
			check("sample_valid", WORD'(exp_valid), WORD'(sample_valid));
			check("data_out", exp_data, data_out);
		end
	end

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			passed++;
			$display("test %s passed", test_name);
		end else begin
			failed++;
			$display("test %s failed with %0d mismatches", test_name, test_errors);
		end
	endtask

	task automatic report_counts();
		$display("tests passed %0d, failed %0d, mismatches %0d", passed, failed, errors);
	endtask

endmodule

/* verification/function_generator_tb.sv */
`timescale 1ns/1ps

`include "wavegen_consts.svh"

// runs the scenario table against the waveform generator
module function_generator_tb;

	localparam int ROWS = 8;
	localparam int RESET_CYCLES = 8;
	// quiet cycles after reset, no start
	localparam int IDLE_CYCLES = 20;

	typedef enum {fill_ramp, fill_const, fill_random} fill_kind_e;

	// one playback scenario
	typedef struct {
		string name;
		fill_kind_e kind;
		wavegen_pkg::sample_t value;
		logic [`WG_CHANNELS-1:0] load_mask;
		wavegen_pkg::length_t length;
		wavegen_pkg::play_mode_e mode;
		logic [`WG_CHANNELS-1:0] enable;
		int play_cycles;
		bit stop;
		// play cycle that carries a second start, 0 for none
		int restart_at;
	} row_t;

	row_t rows [ROWS];
	int timeout_limit;
	int cycle_count;

	logic clock = 1'b0;
	logic reset;
	logic [`WG_CHANNEL_WIDTH-1:0] channel;
	wavegen_pkg::address_t write_address;
	wavegen_pkg::sample_t data_in;
	logic write_enable;
	logic start;
	logic stop;
	wavegen_pkg::play_mode_e mode;
	wavegen_pkg::length_t length;
	logic [`WG_CHANNELS-1:0] channel_enable;
	logic [`WG_CHANNELS*`WG_DATA_WIDTH-1:0] data_out;
	logic sample_valid;

	// 4 ns period
	always #2 clock = ~clock;

	function_generator uut (.*);

	function_generator_checker checker_inst (.*);

	bind function_generator function_generator_asserts asserts_inst (
		.clock(clock), .reset(reset), .start(start), .stop(stop), .length(length),
		.read_address(read_address), .playing(playing), .sample_valid(sample_valid)
	);

	// samples written per channel, zero length still writes one
	function automatic int fill_count(input row_t r);
		return (r.length == '0) ? 1 : int'(r.length);
	endfunction

	// channels get offset ramps and constants so their slices differ
	function automatic wavegen_pkg::sample_t fill_sample(input row_t r, input int ch,
			input int a);
		case (r.kind)
			fill_ramp: return wavegen_pkg::sample_t'(r.value + a + 64 * ch);
			fill_const: return wavegen_pkg::sample_t'(r.value + 8'h11 * ch);
			default: return wavegen_pkg::sample_t'($urandom);
		endcase
	endfunction

	task automatic run_row(input row_t r);
		checker_inst.begin_test(r.name);
		mode = r.mode;
		length = r.length;
		channel_enable = r.enable;
		for (int c = 0; c < `WG_CHANNELS; c++) begin
			if (r.load_mask[c]) begin
				for (int a = 0; a < fill_count(r); a++) begin
					write_enable = 1'b1;
					channel = (`WG_CHANNEL_WIDTH)'(c);
					write_address = wavegen_pkg::address_t'(a);
					data_in = fill_sample(r, c, a);
					@(negedge clock);
				end
			end
		end
		write_enable = 1'b0;
		start = 1'b1;
		@(negedge clock);
		for (int i = 1; i <= r.play_cycles; i++) begin
			start = (i == r.restart_at);
			@(negedge clock);
		end
		start = 1'b0;
		if (r.stop) begin
			stop = 1'b1;
			@(negedge clock);
			stop = 1'b0;
		end
		// wait for the output to go quiet
		while (sample_valid !== 1'b0) begin
			@(negedge clock);
		end
		repeat (4) @(negedge clock);
		checker_inst.end_test();
	endtask

	// cycle counter against a hung run
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > timeout_limit) begin
			$display("timeout, run still busy after %0d cycles", timeout_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h3c96));
		reset = 1'b1;
		channel = '0;
		write_address = '0;
		data_in = '0;
		write_enable = 1'b0;
		start = 1'b0;
		stop = 1'b0;
		mode = wavegen_pkg::mode_loop;
		length = '0;
		channel_enable = '0;
		// name, fill, value, load, length, mode, enable, play, stop, restart
		rows[0] = '{"ramp_loop", fill_ramp, 8'h00, 2'b01, 16, wavegen_pkg::mode_loop, 2'b01,
			40, 1, 0};
		rows[1] = '{"single_len1", fill_random, 0, 2'b11, 1, wavegen_pkg::mode_single, 2'b11,
			6, 0, 0};
		rows[2] = '{"single_full", fill_random, 0, 2'b01, 1024, wavegen_pkg::mode_single, 2'b01,
			1030, 0, 0};
		rows[3] = '{"single_len0", fill_const, 8'h5a, 2'b11, 0, wavegen_pkg::mode_single, 2'b11,
			4, 0, 0};
		rows[4] = '{"two_channels", fill_ramp, 8'h10, 2'b11, 32, wavegen_pkg::mode_loop, 2'b11,
			50, 1, 0};
		rows[5] = '{"ch0_gated", fill_const, 8'ha0, 2'b11, 8, wavegen_pkg::mode_loop, 2'b10,
			20, 1, 0};
		rows[6] = '{"single_stop", fill_ramp, 8'h00, 2'b11, 64, wavegen_pkg::mode_single, 2'b11,
			20, 1, 0};
		rows[7] = '{"restart", fill_ramp, 8'h80, 2'b11, 24, wavegen_pkg::mode_loop, 2'b11,
			40, 1, 13};
		timeout_limit = RESET_CYCLES + IDLE_CYCLES;
		foreach (rows[i]) begin
			timeout_limit += $countones(rows[i].load_mask) * fill_count(rows[i]);
			timeout_limit += rows[i].play_cycles + 16;
		end
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		checker_inst.begin_test("reset_state");
		repeat (IDLE_CYCLES) @(negedge clock);
		checker_inst.end_test();
		foreach (rows[i]) begin
			run_row(rows[i]);
		end
		checker_inst.report_counts();
		if (checker_inst.errors == 0 && checker_inst.failed == 0
				&& uut.asserts_inst.failures == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+include
source/wavegen_pkg.sv
source/wave_write_if.sv
source/waveform_ram.sv
source/playback_sequencer.sv
source/function_generator.sv
verification/function_generator_asserts.sv
verification/function_generator_checker.sv
verification/function_generator_tb.sv

/* Bender.yml */
package:
  name: function_generator

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/wavegen_pkg.sv
      - source/wave_write_if.sv
      - source/waveform_ram.sv
      - source/playback_sequencer.sv
      - source/function_generator.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/function_generator_asserts.sv
      - verification/function_generator_checker.sv
      - verification/function_generator_tb.sv
